// File: hw/axil_pkg.sv
// Shared AXI-Lite read-path widths, response codes, channel payloads and sizes; import with axil_pkg::*
package axil_pkg;

    // Bus widths
    localparam int AXIL_ADDR_W = 32;
    localparam int AXIL_DATA_W = 32;
    localparam int AXIL_PROT_W = 3;
    localparam int AXIL_RESP_W = 2;

    // Plain vector types for bus fields
    typedef logic [AXIL_ADDR_W-1:0] axil_addr_t;
    typedef logic [AXIL_DATA_W-1:0] axil_data_t;
    // Bit 0 set marks a privileged access
    typedef logic [AXIL_PROT_W-1:0] axil_prot_t;
    typedef logic [AXIL_RESP_W-1:0] axil_resp_t;

    // Skid buffer occupancy
    typedef logic [3:0] count_t;

    // Response codes
    localparam axil_resp_t RESP_OKAY   = 2'b00;
    localparam axil_resp_t RESP_SLVERR = 2'b10;
    localparam axil_resp_t RESP_DECERR = 2'b11;

    // AR payload, 35 bits
    typedef struct packed {
        axil_addr_t addr;
        axil_prot_t prot;
    } axil_ar_t;

    // R payload, 34 bits
    typedef struct packed {
        axil_data_t data;
        axil_resp_t resp;
    } axil_r_t;

    // Table depth and first privileged word
    localparam int ROM_WORDS     = 16;
    localparam int ROM_PRIV_BASE = 8;

    // Skid buffer depths per channel
    localparam int SKID_DEPTH_AR = 2;
    localparam int SKID_DEPTH_R  = 4;

endpackage : axil_pkg

// File: hw/gaxi_skid_buffer.sv
// Valid/ready skid FIFO with occupancy count; instantiate per channel with DEPTH and payload_t
`timescale 1ns/1ps

module gaxi_skid_buffer
    import axil_pkg::*;
#(
    parameter int  DEPTH     = 2,
    parameter type payload_t = axil_data_t
) (
    input  logic     aclk,
    input  logic     reset,

    // Write side
    input  logic     wr_valid,
    output logic     wr_ready,
    input  payload_t wr_data,

    // Read side
    output logic     rd_valid,
    input  logic     rd_ready,
    output payload_t rd_data,
    output count_t   rd_count
);

    // Pointer width, at least one bit
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam logic [PTR_W-1:0] LAST_SLOT = PTR_W'(DEPTH - 1);
    localparam count_t FULL_COUNT = count_t'(DEPTH);

    // Storage
    payload_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    count_t           count;
    count_t           count_next;
    logic             push;
    logic             pop;

    // Handshakes on each side
    assign push = wr_valid && wr_ready;
    assign pop  = rd_valid && rd_ready;

    // Occupancy after this cycle
    always_comb begin
        case ({push, pop})
            2'b10:   count_next = count + count_t'(1);
            2'b01:   count_next = count - count_t'(1);
            // Push and pop together leave it unchanged
            default: count_next = count;
        endcase
    end

    // Pointers, count and registered ready
    always_ff @(posedge aclk) begin
        if (reset) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            // Held low for the first cycle out of reset
            wr_ready <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
            end
            count    <= count_next;
            // Drops only when every slot is taken
            wr_ready <= (count_next != FULL_COUNT);
        end
    end

    // Payload write
    always_ff @(posedge aclk) begin
        if (push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // Head of queue, valid the cycle after a push
    assign rd_valid = (count != '0);
    assign rd_data  = mem[rd_ptr];
    assign rd_count = count;

endmodule : gaxi_skid_buffer

// File: hw/axil4_master_rd.sv
// AXI-Lite read bridge with skid buffers on AR and R plus a busy flag for clock gating
`timescale 1ns/1ps

module axil4_master_rd
    import axil_pkg::*;
(
    input  logic     aclk,
    input  logic     reset,

    // Requester AR channel
    input  axil_ar_t fub_ar,
    input  logic     fub_arvalid,
    output logic     fub_arready,

    // Requester R channel
    output axil_r_t  fub_r,
    output logic     fub_rvalid,
    input  logic     fub_rready,

    // Slave-facing AR channel
    output axil_ar_t m_ar,
    output logic     m_arvalid,
    input  logic     m_arready,

    // Slave-facing R channel
    input  axil_r_t  m_r,
    input  logic     m_rvalid,
    output logic     m_rready,

    // High while any read is in flight
    output logic     busy
);

    // Occupancy of each buffer
    count_t int_ar_count;
    count_t int_r_count;

    // Activity anywhere in the bridge or arriving at it
    assign busy = (int_ar_count != '0) || (int_r_count != '0) ||
                  fub_arvalid || m_rvalid;

    // Requests toward the slave
    gaxi_skid_buffer #(
        .DEPTH     (SKID_DEPTH_AR),
        .payload_t (axil_ar_t)
    ) ar_channel (
        .aclk     (aclk),
        .reset    (reset),
        .wr_valid (fub_arvalid),
        .wr_ready (fub_arready),
        .wr_data  (fub_ar),
        .rd_valid (m_arvalid),
        .rd_ready (m_arready),
        .rd_data  (m_ar),
        .rd_count (int_ar_count)
    );

    // Responses back to the requester
    gaxi_skid_buffer #(
        .DEPTH     (SKID_DEPTH_R),
        .payload_t (axil_r_t)
    ) r_channel (
        .aclk     (aclk),
        .reset    (reset),
        .wr_valid (m_rvalid),
        .wr_ready (m_rready),
        .wr_data  (m_r),
        .rd_valid (fub_rvalid),
        .rd_ready (fub_rready),
        .rd_data  (fub_r),
        .rd_count (int_r_count)
    );

endmodule : axil4_master_rd

// File: hw/axil4_slave_rd_rom.sv
// Read-only AXI-Lite slave answering from a 16-word table with decode and privilege checks
`timescale 1ns/1ps

module axil4_slave_rd_rom
    import axil_pkg::*;
(
    input  logic     aclk,
    input  logic     reset,

    // AR channel
    input  axil_ar_t s_ar,
    input  logic     s_arvalid,
    output logic     s_arready,

    // R channel
    output axil_r_t  s_r,
    output logic     s_rvalid,
    input  logic     s_rready
);

    // One read outstanding at a time
    typedef enum logic {
        IDLE,
        RESP
    } state_t;

    state_t state;

    // Table contents
    axil_data_t rom [ROM_WORDS];

    // Word index from address bits 31:2
    logic [29:0] word_index;
    axil_r_t     r_next;
    axil_r_t     r_q;

    initial begin
        $readmemh("rom_init.hex", rom);
    end

    assign word_index = s_ar.addr[31:2];

    // Decode and protection check
    always_comb begin
        r_next.data = '0;
        r_next.resp = RESP_OKAY;
        if (word_index >= 30'(ROM_WORDS)) begin
            // Past the end of the table
            r_next.resp = RESP_DECERR;
        end else if ((word_index >= 30'(ROM_PRIV_BASE)) && !s_ar.prot[0]) begin
            // Upper words need a privileged access
            r_next.resp = RESP_SLVERR;
        end else begin
            r_next.data = rom[word_index[$clog2(ROM_WORDS)-1:0]];
        end
    end

    // Ready only while idle
    assign s_arready = (state == IDLE);
    assign s_rvalid  = (state == RESP);
    assign s_r       = r_q;

    // State machine
    always_ff @(posedge aclk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (s_arvalid) begin
                        state <= RESP;
                    end
                end
                RESP: begin
                    // Back to idle once R is taken
                    if (s_rready) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Response payload, captured on AR acceptance
    always_ff @(posedge aclk) begin
        if (s_arvalid && s_arready) begin
            r_q <= r_next;
        end
    end

endmodule : axil4_slave_rd_rom

// File: hw/axil_rd_subsys.sv
// Read-path subsystem top joining the read bridge to the table slave; the testbench drives fub ports
`timescale 1ns/1ps

module axil_rd_subsys
    import axil_pkg::*;
(
    input  logic     aclk,
    input  logic     reset,

    // Requester AR channel
    input  axil_ar_t fub_ar,
    input  logic     fub_arvalid,
    output logic     fub_arready,

    // Requester R channel
    output axil_r_t  fub_r,
    output logic     fub_rvalid,
    input  logic     fub_rready,

    // Clock gating hint
    output logic     busy
);

    // Bridge to slave, AR side
    axil_ar_t m_ar;
    logic     m_arvalid;
    logic     m_arready;

    // Slave to bridge, R side
    axil_r_t  m_r;
    logic     m_rvalid;
    logic     m_rready;

    // Read bridge
    axil4_master_rd u_master (
        .aclk        (aclk),
        .reset       (reset),
        .fub_ar      (fub_ar),
        .fub_arvalid (fub_arvalid),
        .fub_arready (fub_arready),
        .fub_r       (fub_r),
        .fub_rvalid  (fub_rvalid),
        .fub_rready  (fub_rready),
        .m_ar        (m_ar),
        .m_arvalid   (m_arvalid),
        .m_arready   (m_arready),
        .m_r         (m_r),
        .m_rvalid    (m_rvalid),
        .m_rready    (m_rready),
        .busy        (busy)
    );

    // Table slave
    axil4_slave_rd_rom u_slave (
        .aclk      (aclk),
        .reset     (reset),
        .s_ar      (m_ar),
        .s_arvalid (m_arvalid),
        .s_arready (m_arready),
        .s_r       (m_r),
        .s_rvalid  (m_rvalid),
        .s_rready  (m_rready)
    );

endmodule : axil_rd_subsys

// File: testbench/tb_axil_rd_subsys.sv
// Self-checking random testbench for the AXI-Lite read subsystem; run from the project root
`timescale 1ns/1ps

module tb_axil_rd_subsys
    import axil_pkg::*;
;

    // Reads per test
    localparam int N_PRIV      = 12;
    localparam int N_UNPRIV    = ROM_WORDS;
    localparam int N_DECERR    = 10;
    localparam int N_BURST     = 40;
    localparam int TOTAL_READS = N_PRIV + N_UNPRIV + N_DECERR + N_BURST;

    logic     aclk;
    logic     reset;
    axil_ar_t fub_ar;
    logic     fub_arvalid;
    logic     fub_arready;
    axil_r_t  fub_r;
    logic     fub_rvalid;
    logic     fub_rready;
    logic     busy;

    // Reference table and in-order queues
    axil_data_t rom_model [ROM_WORDS];
    axil_ar_t   pending_ar [$];
    axil_r_t    expected_r [$];
    integer     seed;
    int         checks;
    int         errors;

    axil_rd_subsys u_dut (
        .aclk        (aclk),
        .reset       (reset),
        .fub_ar      (fub_ar),
        .fub_arvalid (fub_arvalid),
        .fub_arready (fub_arready),
        .fub_r       (fub_r),
        .fub_rvalid  (fub_rvalid),
        .fub_rready  (fub_rready),
        .busy        (busy)
    );

    // 100 ns period
    always #50 aclk = ~aclk;

    // Range decode before the privilege rule
    function automatic axil_r_t predict_read(input axil_ar_t ar);
        axil_r_t r;
        r.data = '0;
        r.resp = RESP_OKAY;
        if (ar.addr[31:2] >= ROM_WORDS) begin
            r.resp = RESP_DECERR;
        end else if ((ar.addr[31:2] >= ROM_PRIV_BASE) && !ar.prot[0]) begin
            r.resp = RESP_SLVERR;
        end else begin
            r.data = rom_model[ar.addr[5:2]];
        end
        return r;
    endfunction

    task automatic check_r(input axil_r_t exp, input axil_r_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("mismatch fub_r: exp data 0x%08h resp 0x%1h, act data 0x%08h resp 0x%1h",
                     exp.data, exp.resp, act.data, act.resp);
        end
    endtask

    // Any 1-bit status flag
    task automatic check_busy(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("mismatch %s: expected 0x%1h actual 0x%1h", name, exp, act);
        end
    endtask

    // Request plus its prediction
    task automatic queue_read(input axil_addr_t addr, input axil_prot_t prot);
        axil_ar_t ar;
        ar.addr = addr;
        ar.prot = prot;
        pending_ar.push_back(ar);
        expected_r.push_back(predict_read(ar));
    endtask

    // Back-to-back issue with sampling at negedge and driving at posedge
    task automatic run_traffic(input bit random_ready);
        bit      ar_fire;
        bit      busy_exp;
        axil_r_t exp;
        while ((pending_ar.size() > 0) || (expected_r.size() > 0)) begin
            @(negedge aclk);
            ar_fire  = fub_arvalid && fub_arready;
            // Offered or accepted reads not yet answered
            busy_exp = fub_arvalid || (expected_r.size() > pending_ar.size());
            check_busy("busy", busy_exp, busy);
            if (fub_rvalid && fub_rready) begin
                exp = expected_r.pop_front();
                check_r(exp, fub_r);
            end
            @(posedge aclk);
            if (ar_fire) begin
                pending_ar.delete(0);
            end
            if (pending_ar.size() > 0) begin
                fub_ar      <= pending_ar[0];
                fub_arvalid <= 1'b1;
            end else begin
                fub_arvalid <= 1'b0;
            end
            fub_rready <= random_ready ? 1'($random(seed)) : 1'b1;
        end
        fub_rready <= 1'b1;
    endtask

    task automatic finish_test(input string name, input int start_errors);
        $display("test %s finished with %0d errors", name, errors - start_errors);
    endtask

    // Watchdog sized from the read count
    initial begin
        repeat (TOTAL_READS * 40) @(posedge aclk);
        $display("Timeout: reads still outstanding after %0d cycles", TOTAL_READS * 40);
        $display("Test failed");
        $finish;
    end

    initial begin
        int         idx;
        int         wait_cycles;
        int         start_errors;
        axil_addr_t addr;
        aclk        = 1'b0;
        reset       = 1'b1;
        fub_ar      = '0;
        fub_arvalid = 1'b0;
        fub_rready  = 1'b1;
        seed        = 55653;
        checks      = 0;
        errors      = 0;
        $readmemh("rom_init.hex", rom_model);

        // Quiet outputs out of reset before arready rises
        start_errors = errors;
        repeat (2) @(posedge aclk);
        reset <= 1'b0;
        @(negedge aclk);
        check_busy("fub_arready", 1'b0, fub_arready);
        check_busy("fub_rvalid", 1'b0, fub_rvalid);
        check_busy("busy", 1'b0, busy);
        wait_cycles = 0;
        while (!fub_arready && (wait_cycles < 4)) begin
            @(negedge aclk);
            wait_cycles++;
        end
        if (!fub_arready) begin
            errors++;
            $display("error: fub_arready never rose after reset");
        end
        finish_test("reset", start_errors);

        // Privileged reads in range
        start_errors = errors;
        for (int i = 0; i < N_PRIV; i++) begin
            idx = $unsigned($random(seed)) % ROM_WORDS;
            queue_read({30'(idx), 2'($random(seed))}, 3'($random(seed)) | 3'b001);
        end
        run_traffic(1'b0);
        finish_test("privileged", start_errors);

        // Unprivileged sweep over every word
        start_errors = errors;
        for (int i = 0; i < N_UNPRIV; i++) begin
            queue_read({30'(i), 2'b00}, 3'($random(seed)) & 3'b110);
        end
        run_traffic(1'b0);
        finish_test("unprivileged", start_errors);

        // Addresses beyond the table
        start_errors = errors;
        for (int i = 0; i < N_DECERR; i++) begin
            addr = $random(seed);
            if (addr[31:2] < ROM_WORDS) begin
                addr[31] = 1'b1;
            end
            queue_read(addr, 3'($random(seed)));
        end
        run_traffic(1'b0);
        finish_test("decode error", start_errors);

        // Mixed burst under R back-pressure
        start_errors = errors;
        for (int i = 0; i < N_BURST; i++) begin
            idx = $unsigned($random(seed)) % 24;
            queue_read({30'(idx), 2'($random(seed))}, 3'($random(seed)));
        end
        run_traffic(1'b1);
        finish_test("burst", start_errors);

        // Idle once drained
        start_errors = errors;
        @(negedge aclk);
        check_busy("busy", 1'b0, busy);
        check_busy("fub_rvalid", 1'b0, fub_rvalid);
        finish_test("idle", start_errors);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule : tb_axil_rd_subsys

// File: axil_rd_subsys.f
hw/axil_pkg.sv
hw/gaxi_skid_buffer.sv
hw/axil4_master_rd.sv
hw/axil4_slave_rd_rom.sv
hw/axil_rd_subsys.sv
testbench/tb_axil_rd_subsys.sv

// File: Bender.yml
package:
  name: axil_rd_subsys

sources:
  - hw/axil_pkg.sv
  - hw/gaxi_skid_buffer.sv
  - hw/axil4_master_rd.sv
  - hw/axil4_slave_rd_rom.sv
  - hw/axil_rd_subsys.sv
  - target: test
    files:
      - testbench/tb_axil_rd_subsys.sv

// File: rom_init.hex
// One 32-bit table word per line in hex, word 0 first
1a2b3c4d
00000001
deadbeef
0badf00d
12345678
87654321
cafe0006
5a5a5a5a
a5a5a5a5
0000ffff
ffff0000
c0ffee0b
13579bdf
2468ace0
7e7e7e7e
f00d000f
